//--- logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int PR_BITS   = 6;
    localparam int ROB_DEPTH = 32;
    localparam int ROB_BITS  = 5;
    localparam int FL_DEPTH  = 32;
    localparam int FL_BITS   = 5;
    localparam int WIDTH     = 3;

    // ========================================
    // Vector types
    // ========================================
    typedef logic [PR_BITS-1:0]  preg_t;
    typedef logic [4:0]          areg_t;
    typedef logic [ROB_BITS-1:0] rob_idx_t;
    typedef logic [FL_BITS-1:0]  fl_idx_t;
    // Holds 0 to FL_DEPTH inclusive.
    typedef logic [FL_BITS:0]    fl_count_t;
    typedef logic [XLEN-1:0]     pc_t;

endpackage

`default_nettype wire

//--- logic/rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob import ooo_pkg::*; (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire  [2:0]             dispatch_en,
    input  wire  areg_t [2:0]      dispatch_arch_reg,
    input  wire  preg_t [2:0]      dispatch_tnew,
    input  wire  preg_t [2:0]      dispatch_told,
    input  wire  [2:0]             dispatch_is_store,
    input  wire  [2:0]             dispatch_halt,
    input  wire                    complete_en,
    input  wire  rob_idx_t         complete_idx,
    input  wire                    complete_mispredict,
    input  wire  pc_t              complete_target_pc,
    input  wire  [2:0]             retire_valid,
    input  wire                    recover_en,
    output logic [2:0]             head_valid,
    output logic [2:0]             head_completed,
    output logic [2:0]             head_mispredict,
    output logic [2:0]             head_halt,
    output logic [2:0]             head_is_store,
    output areg_t [2:0]            head_arch_reg,
    output preg_t [2:0]            head_tnew,
    output preg_t [2:0]            head_told,
    output pc_t [2:0]              head_target_pc,
    output rob_idx_t [2:0]         dispatch_rob_idx,
    output logic                   rob_space_low,
    output logic                   halted
);

    logic [ROB_DEPTH-1:0] completed;
    logic [ROB_DEPTH-1:0] mispredict;
    logic [ROB_DEPTH-1:0] halt_bit;
    logic [ROB_DEPTH-1:0] is_store;
    areg_t                arch_reg [ROB_DEPTH];
    preg_t                tnew [ROB_DEPTH];
    preg_t                told [ROB_DEPTH];
    pc_t                  target_pc [ROB_DEPTH];

    rob_idx_t             head;
    rob_idx_t             tail;
    logic [ROB_BITS:0]    count;
    rob_idx_t [2:0]       head_idx;
    rob_idx_t             n_disp;
    rob_idx_t             n_ret;

    // Slot 2 is the oldest, so it sits at the head and takes the tail first.
    always_comb begin
        for (int k = 0; k < WIDTH; k++) begin
            head_idx[k]         = head + rob_idx_t'(WIDTH - 1 - k);
            dispatch_rob_idx[k] = tail + rob_idx_t'(WIDTH - 1 - k);
            head_valid[k]       = count > (ROB_BITS + 1)'(WIDTH - 1 - k);
            head_completed[k]   = completed[head_idx[k]];
            head_mispredict[k]  = mispredict[head_idx[k]];
            head_halt[k]        = halt_bit[head_idx[k]];
            head_is_store[k]    = is_store[head_idx[k]];
            head_arch_reg[k]    = arch_reg[head_idx[k]];
            head_tnew[k]        = tnew[head_idx[k]];
            head_told[k]        = told[head_idx[k]];
            head_target_pc[k]   = target_pc[head_idx[k]];
        end
    end

    assign n_disp = rob_idx_t'(dispatch_en[2]) + rob_idx_t'(dispatch_en[1])
                  + rob_idx_t'(dispatch_en[0]);
    assign n_ret  = rob_idx_t'(retire_valid[2]) + rob_idx_t'(retire_valid[1])
                  + rob_idx_t'(retire_valid[0]);

    assign rob_space_low = count > (ROB_BITS + 1)'(ROB_DEPTH - WIDTH);

    always_ff @(posedge clock) begin
        for (int k = 0; k < WIDTH; k++) begin
            if (dispatch_en[k]) begin
                arch_reg[dispatch_rob_idx[k]] <= dispatch_arch_reg[k];
                tnew[dispatch_rob_idx[k]]     <= dispatch_tnew[k];
                told[dispatch_rob_idx[k]]     <= dispatch_told[k];
                is_store[dispatch_rob_idx[k]] <= dispatch_is_store[k];
                halt_bit[dispatch_rob_idx[k]] <= dispatch_halt[k];
            end
        end
        if (complete_en) begin
            mispredict[complete_idx] <= complete_mispredict;
            target_pc[complete_idx]  <= complete_target_pc;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            completed <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            halted    <= 1'b0;
        end else begin
            for (int k = 0; k < WIDTH; k++) begin
                if (dispatch_en[k]) begin
                    completed[dispatch_rob_idx[k]] <= 1'b0;
                end
            end
            if (complete_en) begin
                completed[complete_idx] <= 1'b1;
            end
            if (|(retire_valid & head_halt)) begin
                halted <= 1'b1;
            end
            head <= head + n_ret;
            // Everything younger than the mispredict is squashed.
            if (recover_en) begin
                tail  <= head + n_ret;
                count <= '0;
            end else begin
                tail  <= tail + n_disp;
                count <= count + {1'b0, n_disp} - {1'b0, n_ret};
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage import ooo_pkg::*; (
    input  wire  [2:0]                  head_valid,
    input  wire  [2:0]                  head_completed,
    input  wire  [2:0]                  head_mispredict,
    input  wire  [2:0]                  head_halt,
    input  wire  [2:0]                  head_is_store,
    input  wire  areg_t [2:0]           head_arch_reg,
    input  wire  preg_t [2:0]           head_tnew,
    input  wire  pc_t [2:0]             head_target_pc,
    input  wire                         halted,
    input  wire  fl_count_t             fl_distance,
    input  wire  fl_idx_t               fl_head,
    input  wire  preg_t [ARCH_REGS-1:0] arch_map,
    output logic [2:0]                  retire_en,
    output logic [2:0]                  retire_valid,
    output logic [2:0]                  sq_retire_en,
    output logic                        recover_en,
    output pc_t                         target_pc,
    output preg_t [ARCH_REGS-1:0]       recover_map,
    output fl_idx_t                     recover_head,
    output logic                        halt,
    output logic [1:0]                  inst_count
);

    fl_count_t rewind_dist;

    // Walk from the oldest slot and stop at the first entry that cannot go.
    always_comb begin
        logic go;
        logic writes;
        go           = !halted;
        retire_en    = '0;
        retire_valid = '0;
        sq_retire_en = '0;
        recover_en   = 1'b0;
        target_pc    = '0;
        halt         = 1'b0;
        recover_map  = arch_map;
        rewind_dist  = fl_distance;
        for (int k = WIDTH - 1; k >= 0; k--) begin
            writes = head_arch_reg[k] != '0;
            if (go && head_valid[k] && head_completed[k]) begin
                retire_valid[k] = 1'b1;
                retire_en[k]    = writes;
                sq_retire_en[k] = head_is_store[k];
                if (writes) begin
                    recover_map[head_arch_reg[k]] = head_tnew[k];
                    rewind_dist = rewind_dist - fl_count_t'(1);
                end
                // A mispredicting branch retires itself, younger slots do not.
                if (head_mispredict[k]) begin
                    recover_en = 1'b1;
                    target_pc  = head_target_pc[k];
                    go         = 1'b0;
                end
                if (head_halt[k]) begin
                    halt = 1'b1;
                    go   = 1'b0;
                end
            end else begin
                go = 1'b0;
            end
        end
    end

    // Tags held by squashed writers go back to the free list head.
    assign recover_head = fl_head - rewind_dist[FL_BITS-1:0];

    assign inst_count = 2'(retire_valid[2]) + 2'(retire_valid[1]) + 2'(retire_valid[0]);

endmodule

`default_nettype wire

//--- logic/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import ooo_pkg::*; (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire  [2:0]          alloc_en,
    input  wire  [2:0]          release_en,
    input  wire  preg_t [2:0]   release_preg,
    input  wire                 recover_en,
    input  wire  fl_idx_t       recover_head,
    output preg_t [2:0]         alloc_preg,
    output fl_idx_t             fl_head,
    output fl_count_t           fl_distance,
    output logic                fl_low
);

    preg_t          list [FL_DEPTH];
    fl_idx_t        tail;
    fl_idx_t        tail_next;
    fl_idx_t [2:0]  alloc_idx;
    fl_idx_t [2:0]  rel_idx;
    fl_idx_t        n_alloc;
    fl_idx_t        n_rel;

    // Packed slots, a slot that does not take a tag leaves no hole.
    always_comb begin
        alloc_idx[2] = fl_head;
        alloc_idx[1] = alloc_idx[2] + fl_idx_t'(alloc_en[2]);
        alloc_idx[0] = alloc_idx[1] + fl_idx_t'(alloc_en[1]);
        rel_idx[2]   = tail;
        rel_idx[1]   = rel_idx[2] + fl_idx_t'(release_en[2]);
        rel_idx[0]   = rel_idx[1] + fl_idx_t'(release_en[1]);
        for (int k = 0; k < WIDTH; k++) begin
            alloc_preg[k] = alloc_en[k] ? list[alloc_idx[k]] : '0;
        end
    end

    assign n_alloc   = alloc_idx[0] + fl_idx_t'(alloc_en[0]) - fl_head;
    assign n_rel     = rel_idx[0] + fl_idx_t'(release_en[0]) - tail;
    assign tail_next = tail + n_rel;
    assign fl_low    = fl_distance > fl_count_t'(FL_DEPTH - WIDTH);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FL_DEPTH; i++) begin
                list[i] <= preg_t'(ARCH_REGS + i);
            end
            fl_head     <= '0;
            tail        <= '0;
            fl_distance <= '0;
        end else begin
            for (int k = 0; k < WIDTH; k++) begin
                if (release_en[k]) begin
                    list[rel_idx[k]] <= release_preg[k];
                end
            end
            tail <= tail_next;
            // A retiring mispredict keeps the distance below FL_DEPTH.
            if (recover_en) begin
                fl_head     <= recover_head;
                fl_distance <= {1'b0, recover_head - tail_next};
            end else begin
                fl_head     <= fl_head + n_alloc;
                fl_distance <= fl_distance + {1'b0, n_alloc} - {1'b0, n_rel};
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table import ooo_pkg::*; (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire  [2:0]                  dispatch_en,
    input  wire  areg_t [2:0]           dispatch_arch_reg,
    input  wire  preg_t [2:0]           dispatch_tnew,
    input  wire                         recover_en,
    input  wire  preg_t [ARCH_REGS-1:0] recover_map,
    output preg_t [2:0]                 dispatch_told
);

    preg_t [ARCH_REGS-1:0] map;
    logic  [2:0]           writes;

    always_comb begin
        for (int k = 0; k < WIDTH; k++) begin
            writes[k] = dispatch_en[k] && dispatch_arch_reg[k] != '0;
        end
    end

    // Older slots in the same group forward their new tag.
    always_comb begin
        for (int k = WIDTH - 1; k >= 0; k--) begin
            dispatch_told[k] = map[dispatch_arch_reg[k]];
            for (int j = WIDTH - 1; j > k; j--) begin
                if (writes[j] && dispatch_arch_reg[j] == dispatch_arch_reg[k]) begin
                    dispatch_told[k] = dispatch_tnew[j];
                end
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (recover_en) begin
            map <= recover_map;
        end else begin
            for (int k = WIDTH - 1; k >= 0; k--) begin
                if (writes[k]) begin
                    map[dispatch_arch_reg[k]] <= dispatch_tnew[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/arch_map_table.sv
`timescale 1ns/1ps
`default_nettype none

module arch_map_table import ooo_pkg::*; (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire  [2:0]            retire_en,
    input  wire  areg_t [2:0]     retire_arch_reg,
    input  wire  preg_t [2:0]     retire_tnew,
    output preg_t [ARCH_REGS-1:0] arch_map
);

    // Slot 0 is written last, so the youngest write wins.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                arch_map[i] <= preg_t'(i);
            end
        end else begin
            for (int k = WIDTH - 1; k >= 0; k--) begin
                if (retire_en[k]) begin
                    arch_map[retire_arch_reg[k]] <= retire_tnew[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/retire_core.sv
`timescale 1ns/1ps
`default_nettype none

module retire_core import ooo_pkg::*; (
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire  [2:0]           dispatch_en,
    input  wire  areg_t [2:0]    dispatch_arch_reg,
    input  wire  [2:0]           dispatch_is_store,
    input  wire  [2:0]           dispatch_halt,
    input  wire                  complete_en,
    input  wire  rob_idx_t       complete_idx,
    input  wire                  complete_mispredict,
    input  wire  pc_t            complete_target_pc,
    output logic                 dispatch_stall,
    output rob_idx_t [2:0]       dispatch_rob_idx,
    output preg_t [2:0]          dispatch_tnew,
    output preg_t [2:0]          dispatch_told,
    output logic [2:0]           retire_en,
    output logic [2:0]           retire_valid,
    output areg_t [2:0]          retire_arch_reg,
    output preg_t [2:0]          retire_tnew,
    output preg_t [2:0]          retire_told,
    output logic [2:0]           sq_retire_en,
    output logic                 recover_en,
    output pc_t                  target_pc,
    output logic                 halt,
    output logic [1:0]           inst_count
);

    logic [2:0]            dispatch_fire;
    logic [2:0]            alloc_en;
    logic [2:0]            head_valid;
    logic [2:0]            head_completed;
    logic [2:0]            head_mispredict;
    logic [2:0]            head_halt;
    logic [2:0]            head_is_store;
    pc_t [2:0]             head_target_pc;
    logic                  rob_space_low;
    logic                  halted;
    logic                  fl_low;
    fl_idx_t               fl_head;
    fl_count_t             fl_distance;
    fl_idx_t               recover_head;
    preg_t [ARCH_REGS-1:0] arch_map;
    preg_t [ARCH_REGS-1:0] recover_map;

    assign dispatch_stall = rob_space_low | fl_low | recover_en;
    assign dispatch_fire  = dispatch_en & {WIDTH{!dispatch_stall}};

    // x0 destinations take no tag.
    always_comb begin
        for (int k = 0; k < WIDTH; k++) begin
            alloc_en[k] = dispatch_fire[k] && dispatch_arch_reg[k] != '0;
        end
    end

    rob u_rob (
        .clock, .rst_n,
        .dispatch_en(dispatch_fire), .dispatch_arch_reg,
        .dispatch_tnew, .dispatch_told, .dispatch_is_store, .dispatch_halt,
        .complete_en, .complete_idx, .complete_mispredict, .complete_target_pc,
        .retire_valid, .recover_en,
        .head_valid, .head_completed, .head_mispredict, .head_halt, .head_is_store,
        .head_arch_reg(retire_arch_reg), .head_tnew(retire_tnew),
        .head_told(retire_told), .head_target_pc,
        .dispatch_rob_idx, .rob_space_low, .halted
    );

    retire_stage u_retire_stage (
        .head_valid, .head_completed, .head_mispredict, .head_halt, .head_is_store,
        .head_arch_reg(retire_arch_reg), .head_tnew(retire_tnew), .head_target_pc,
        .halted, .fl_distance, .fl_head, .arch_map,
        .retire_en, .retire_valid, .sq_retire_en, .recover_en, .target_pc,
        .recover_map, .recover_head, .halt, .inst_count
    );

    free_list u_free_list (
        .clock, .rst_n, .alloc_en,
        .release_en(retire_en), .release_preg(retire_told),
        .recover_en, .recover_head,
        .alloc_preg(dispatch_tnew), .fl_head, .fl_distance, .fl_low
    );

    map_table u_map_table (
        .clock, .rst_n, .dispatch_en(dispatch_fire), .dispatch_arch_reg,
        .dispatch_tnew, .recover_en, .recover_map, .dispatch_told
    );

    arch_map_table u_arch_map_table (
        .clock, .rst_n, .retire_en, .retire_arch_reg,
        .retire_tnew, .arch_map
    );

endmodule

`default_nettype wire

//--- tests/retire_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module retire_core_properties (
    input wire       clock,
    input wire       rst_n,
    input wire [2:0] retire_valid,
    input wire [2:0] retire_en,
    input wire [1:0] inst_count,
    input wire       recover_en
);

    int error_count = 0;

    // Retirement is in order, so only a prefix from slot 2 can go.
    a_prefix: assert property (@(posedge clock) disable iff (!rst_n)
        retire_valid inside {3'b000, 3'b100, 3'b110, 3'b111})
        else begin
            $error("retire_valid %b is not a prefix from slot 2", retire_valid);
            error_count++;
        end

    a_subset: assert property (@(posedge clock) disable iff (!rst_n)
        (retire_en & ~retire_valid) == 3'b000)
        else begin
            $error("retire_en %b outside retire_valid %b", retire_en, retire_valid);
            error_count++;
        end

    a_count: assert property (@(posedge clock) disable iff (!rst_n)
        inst_count == $countones(retire_valid))
        else begin
            $error("inst_count %0d does not match retire_valid %b", inst_count, retire_valid);
            error_count++;
        end

    // The mispredicting branch always retires itself.
    a_recover: assert property (@(posedge clock) disable iff (!rst_n)
        recover_en |-> retire_valid != 3'b000)
        else begin
            $error("recover_en high with nothing retiring");
            error_count++;
        end

endmodule

bind retire_core retire_core_properties u_properties (
    .clock(clock),
    .rst_n(rst_n),
    .retire_valid(retire_valid),
    .retire_en(retire_en),
    .inst_count(inst_count),
    .recover_en(recover_en)
);

`default_nettype wire

//--- tests/retire_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module retire_core_tb import ooo_pkg::*; ();

    logic           clock;
    logic           rst_n;
    logic [2:0]     dispatch_en;
    areg_t [2:0]    dispatch_arch_reg;
    logic [2:0]     dispatch_is_store;
    logic [2:0]     dispatch_halt;
    logic           complete_en;
    rob_idx_t       complete_idx;
    logic           complete_mispredict;
    pc_t            complete_target_pc;
    logic           dispatch_stall;
    rob_idx_t [2:0] dispatch_rob_idx;
    preg_t [2:0]    dispatch_tnew;
    preg_t [2:0]    dispatch_told;
    logic [2:0]     retire_en;
    logic [2:0]     retire_valid;
    areg_t [2:0]    retire_arch_reg;
    preg_t [2:0]    retire_tnew;
    preg_t [2:0]    retire_told;
    logic [2:0]     sq_retire_en;
    logic           recover_en;
    pc_t            target_pc;
    logic           halt;
    logic [1:0]     inst_count;

    // ========================================
    // Reference model
    // ========================================
    int          m_head;
    int          m_count;
    int          m_areg [ROB_DEPTH];
    int          m_tnew [ROB_DEPTH];
    int          m_told [ROB_DEPTH];
    bit          m_done [ROB_DEPTH];
    bit          m_misp [ROB_DEPTH];
    bit          m_store [ROB_DEPTH];
    bit          m_halt [ROB_DEPTH];
    logic [31:0] m_tpc [ROB_DEPTH];
    bit          m_halted;
    int          model_spec [ARCH_REGS];
    int          model_arch [ARCH_REGS];
    int          free_q [$];

    logic [2:0]  exp_rv;
    logic [2:0]  exp_re;
    logic [2:0]  exp_sq;
    logic [2:0]  exp_fire;
    int          exp_cnt;
    bit          exp_recover;
    bit          exp_halt;
    bit          exp_stall;
    logic [31:0] exp_tpc;
    int          exp_idx [WIDTH];
    int          exp_tnew [WIDTH];
    int          exp_told [WIDTH];

    logic [31:0] rng_state;
    int          mode;
    int          n_recover;
    bit          seen_halt;
    int          waited;

    retire_core UUT (.*);

    always #20 clock = ~clock;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: actual %0h expected %0h",
                     $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    endtask

    // State changes at a rising edge, from the inputs and expectations of the cycle before.
    task automatic apply_edge();
        int idx;
        if (complete_en) begin
            m_done[complete_idx] = 1'b1;
            m_misp[complete_idx] = complete_mispredict;
            m_tpc[complete_idx]  = complete_target_pc;
        end
        for (int k = WIDTH - 1; k >= 0; k--) begin
            if (exp_rv[k]) begin
                if (m_areg[m_head] != 0) begin
                    model_arch[m_areg[m_head]] = m_tnew[m_head];
                    free_q.push_back(m_told[m_head]);
                end
                m_halted = m_halted | m_halt[m_head];
                m_head   = (m_head + 1) % ROB_DEPTH;
                m_count  = m_count - 1;
            end
        end
        if (exp_recover) begin
            // Squashed tags go back to the front, oldest first.
            for (int j = m_count - 1; j >= 0; j--) begin
                idx = (m_head + j) % ROB_DEPTH;
                if (m_areg[idx] != 0) begin
                    free_q.push_front(m_tnew[idx]);
                end
            end
            m_count    = 0;
            model_spec = model_arch;
            n_recover  = n_recover + 1;
        end
        for (int k = WIDTH - 1; k >= 0; k--) begin
            if (exp_fire[k]) begin
                idx          = exp_idx[k];
                m_areg[idx]  = dispatch_arch_reg[k];
                m_told[idx]  = exp_told[k];
                m_store[idx] = dispatch_is_store[k];
                m_halt[idx]  = dispatch_halt[k];
                m_done[idx]  = 1'b0;
                m_tnew[idx]  = 0;
                if (m_areg[idx] != 0) begin
                    m_tnew[idx] = free_q.pop_front();
                    model_spec[m_areg[idx]] = m_tnew[idx];
                end
                m_count = m_count + 1;
            end
        end
    endtask

    task automatic predict_retire();
        int idx;
        bit go;
        go          = !m_halted;
        exp_rv      = '0;
        exp_re      = '0;
        exp_sq      = '0;
        exp_cnt     = 0;
        exp_recover = 1'b0;
        exp_halt    = 1'b0;
        exp_tpc     = '0;
        for (int k = WIDTH - 1; k >= 0; k--) begin
            idx = (m_head + WIDTH - 1 - k) % ROB_DEPTH;
            if (go && m_count > WIDTH - 1 - k && m_done[idx]) begin
                exp_rv[k] = 1'b1;
                exp_re[k] = m_areg[idx] != 0;
                exp_sq[k] = m_store[idx];
                exp_cnt   = exp_cnt + 1;
                if (m_misp[idx]) begin
                    exp_recover = 1'b1;
                    exp_tpc     = m_tpc[idx];
                    go          = 1'b0;
                end
                if (m_halt[idx]) begin
                    exp_halt = 1'b1;
                    go       = 1'b0;
                end
            end else begin
                go = 1'b0;
            end
        end
        exp_stall = m_count > ROB_DEPTH - WIDTH || free_q.size() < WIDTH || exp_recover;
    endtask

    // Renames each slot in age order so younger slots see older writes.
    task automatic predict_dispatch();
        int tmp [ARCH_REGS];
        int pos;
        int a;
        tmp      = model_spec;
        pos      = 0;
        exp_fire = dispatch_en & {WIDTH{!exp_stall}};
        for (int k = WIDTH - 1; k >= 0; k--) begin
            a           = dispatch_arch_reg[k];
            exp_idx[k]  = (m_head + m_count + WIDTH - 1 - k) % ROB_DEPTH;
            exp_told[k] = tmp[a];
            exp_tnew[k] = 0;
            if (exp_fire[k] && a != 0) begin
                exp_tnew[k] = free_q[pos];
                pos         = pos + 1;
                tmp[a]      = exp_tnew[k];
            end
        end
    endtask

    task automatic drive_stimulus();
        logic [31:0] r;
        areg_t       a;
        int          o;
        int          cidx;
        r = xorshift32();
        dispatch_en   <= 3'b000;
        dispatch_halt <= 3'b000;
        complete_en   <= 1'b0;
        if (!exp_stall && (mode == 0 || mode == 3)) begin
            case (r[1:0])
                2'd1: dispatch_en <= 3'b100;
                2'd2: dispatch_en <= 3'b110;
                2'd3: dispatch_en <= 3'b111;
                default: dispatch_en <= 3'b000;
            endcase
        end else if (!exp_stall && mode == 2) begin
            // Halt in slot 2, one younger instruction behind it.
            dispatch_en   <= 3'b110;
            dispatch_halt <= 3'b100;
            mode = 3;
        end
        for (int k = 0; k < WIDTH; k++) begin
            r = xorshift32();
            a = r[4:0];
            if (r[8]) begin
                a = {3'b000, r[1:0]};
            end
            dispatch_arch_reg[k] <= a;
            dispatch_is_store[k] <= r[12:10] == 3'd0;
        end
        r    = xorshift32();
        cidx = -1;
        if (m_count > 0 && r[1:0] != 2'd0) begin
            o = int'(r[20:8]) % m_count;
            for (int i = 0; i < m_count; i++) begin
                if (cidx < 0 && !m_done[(m_head + (o + i) % m_count) % ROB_DEPTH]) begin
                    cidx = (m_head + (o + i) % m_count) % ROB_DEPTH;
                end
            end
        end
        if (cidx >= 0) begin
            r = xorshift32();
            complete_en         <= 1'b1;
            complete_idx        <= rob_idx_t'(cidx);
            complete_mispredict <= mode == 0 && r[4:0] == 5'd0;
            complete_target_pc  <= xorshift32();
        end
    endtask

    task automatic compare_outputs();
        int idx;
        check("dispatch_stall", dispatch_stall, exp_stall);
        check("retire_valid", retire_valid, exp_rv);
        check("retire_en", retire_en, exp_re);
        check("sq_retire_en", sq_retire_en, exp_sq);
        check("inst_count", inst_count, exp_cnt);
        check("recover_en", recover_en, exp_recover);
        check("halt", halt, exp_halt);
        check("assertion errors", UUT.u_properties.error_count, 0);
        if (exp_recover) begin
            check("target_pc", target_pc, exp_tpc);
        end
        for (int k = WIDTH - 1; k >= 0; k--) begin
            idx = (m_head + WIDTH - 1 - k) % ROB_DEPTH;
            if (exp_rv[k]) begin
                check($sformatf("retire_arch_reg[%0d]", k), retire_arch_reg[k], m_areg[idx]);
                check($sformatf("retire_tnew[%0d]", k), retire_tnew[k], m_tnew[idx]);
                check($sformatf("retire_told[%0d]", k), retire_told[k], m_told[idx]);
            end
            if (exp_fire[k]) begin
                check($sformatf("dispatch_rob_idx[%0d]", k), dispatch_rob_idx[k], exp_idx[k]);
                check($sformatf("dispatch_told[%0d]", k), dispatch_told[k], exp_told[k]);
                if (dispatch_arch_reg[k] != '0) begin
                    check($sformatf("dispatch_tnew[%0d]", k), dispatch_tnew[k], exp_tnew[k]);
                end
            end
        end
    endtask

    // Drive just after the rising edge, check at the falling edge.
    task automatic run_cycle();
        @(posedge clock);
        apply_edge();
        predict_retire();
        drive_stimulus();
        @(negedge clock);
        predict_dispatch();
        compare_outputs();
        if (exp_halt) begin
            seen_halt = 1'b1;
        end
    endtask

    initial begin
        clock               = 1'b0;
        rst_n               = 1'b0;
        dispatch_en         = '0;
        dispatch_arch_reg   = '0;
        dispatch_is_store   = '0;
        dispatch_halt       = '0;
        complete_en         = 1'b0;
        complete_idx        = '0;
        complete_mispredict = 1'b0;
        complete_target_pc  = '0;
        rng_state           = 32'd8;
        m_head              = 0;
        m_count             = 0;
        m_halted            = 1'b0;
        mode                = 0;
        n_recover           = 0;
        seen_halt           = 1'b0;
        exp_rv              = '0;
        exp_fire            = '0;
        exp_recover         = 1'b0;
        exp_stall           = 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_spec[i] = i;
            model_arch[i] = i;
        end
        for (int i = 0; i < FL_DEPTH; i++) begin
            free_q.push_back(ARCH_REGS + i);
        end
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        repeat (600) run_cycle();
        check("recoveries seen", n_recover > 0, 1);

        // Drain with no new dispatch and no mispredicts.
        mode   = 1;
        waited = 0;
        while (m_count != 0) begin
            run_cycle();
            waited = waited + 1;
            if (waited > 400) begin
                timeout_fail("the ROB to drain");
            end
        end

        mode   = 2;
        waited = 0;
        while (!seen_halt) begin
            run_cycle();
            waited = waited + 1;
            if (waited > 400) begin
                timeout_fail("the halt instruction to retire");
            end
        end

        // Nothing may retire once halted.
        repeat (20) run_cycle();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
logic/ooo_pkg.sv
logic/rob.sv
logic/retire_stage.sv
logic/free_list.sv
logic/map_table.sv
logic/arch_map_table.sv
logic/retire_core.sv
tests/retire_core_properties.sv
tests/retire_core_tb.sv
